/* hw/sd_consts.svh */
`ifndef SD_CONSTS_SVH
`define SD_CONSTS_SVH

////////////////////
// z80 port map
////////////////////

// sd data port, low address byte
`define SD_DATA_PORT 8'h57

// sd control and status port
`define SD_CTRL_PORT 8'h77

////////////////////
// queues and spi
////////////////////

// entries in each of the two queues
`define SD_FIFO_DEPTH 8

// fclk cycles per sdclk half period
`define SD_CLK_DIV 2

`endif

/* hw/sd_host.sv */
`timescale 1ns/1ns
`default_nettype none

`include "sd_consts.svh"

module sd_host (
	input  wire                        fclk,
	input  wire                        rst_n,

	// z80 port access
	input  wire zport_pkg::port_byte_t a,
	input  wire zport_pkg::port_byte_t din,
	input  wire                        iowr,
	input  wire                        iord,
	output zport_pkg::port_byte_t      dout,
	output logic                       dout_ena,

	// sd card
	output logic                       sdcs_n,
	output logic                       sdclk,
	output logic                       sddo,
	input  wire                        sddi
);

	// transmit path
	wire                   tx_push;
	wire sd_pkg::tx_item_t tx_item;
	wire                   tx_pop;
	wire sd_pkg::tx_item_t tx_head;
	wire                   tx_full;
	wire                   tx_empty;

	// receive path
	wire                   rx_push;
	wire sd_pkg::rx_byte_t rx_byte;
	wire                   rx_pop;
	wire sd_pkg::rx_byte_t rx_head;
	wire                   rx_full;
	wire                   rx_empty;

	wire                   busy;

	zsd_ports u_ports (
		.fclk     (fclk),
		.rst_n    (rst_n),
		.a        (a),
		.din      (din),
		.iowr     (iowr),
		.iord     (iord),
		.dout     (dout),
		.dout_ena (dout_ena),
		.tx_full  (tx_full),
		.tx_push  (tx_push),
		.tx_item  (tx_item),
		.rx_empty (rx_empty),
		.rx_head  (rx_head),
		.rx_pop   (rx_pop),
		.busy     (busy)
	);

	sync_fifo #(
		.payload_t (sd_pkg::tx_item_t),
		.depth     (`SD_FIFO_DEPTH)
	) u_tx_fifo (
		.fclk  (fclk),
		.rst_n (rst_n),
		.push  (tx_push),
		.wdata (tx_item),
		.pop   (tx_pop),
		.rdata (tx_head),
		.full  (tx_full),
		.empty (tx_empty)
	);

	sync_fifo #(
		.payload_t (sd_pkg::rx_byte_t),
		.depth     (`SD_FIFO_DEPTH)
	) u_rx_fifo (
		.fclk  (fclk),
		.rst_n (rst_n),
		.push  (rx_push),
		.wdata (rx_byte),
		.pop   (rx_pop),
		.rdata (rx_head),
		.full  (rx_full),
		.empty (rx_empty)
	);

	sd_spi_master u_spi (
		.fclk     (fclk),
		.rst_n    (rst_n),
		.tx_empty (tx_empty),
		.tx_head  (tx_head),
		.tx_pop   (tx_pop),
		.rx_full  (rx_full),
		.rx_push  (rx_push),
		.rx_byte  (rx_byte),
		.busy     (busy),
		.sdcs_n   (sdcs_n),
		.sdclk    (sdclk),
		.sddo     (sddo),
		.sddi     (sddi)
	);

endmodule

`default_nettype wire

/* hw/sd_pkg.sv */
`default_nettype none

package sd_pkg;

	// shift a byte, or load a new chip select level
	typedef enum logic {
		TX_SHIFT,
		TX_CS
	} tx_kind_t;

	// transmit queue entry
	// for TX_CS, data[0] is the new sdcs_n level
	typedef struct packed {
		tx_kind_t   kind;
		logic [7:0] data;
	} tx_item_t;

	// one byte clocked in from sddi
	typedef logic [7:0] rx_byte_t;

	// spi master FSM
	typedef enum logic [1:0] {
		SPI_IDLE,
		SPI_CS,
		SPI_SHIFT
	} spi_state_t;

endpackage

`default_nettype wire

/* hw/sd_spi_master.sv */
`timescale 1ns/1ns
`default_nettype none

`include "sd_consts.svh"

module sd_spi_master (
	input  wire                   fclk,
	input  wire                   rst_n,

	// transmit queue head
	input  wire                   tx_empty,
	input  wire sd_pkg::tx_item_t tx_head,
	output logic                  tx_pop,

	// receive queue
	input  wire                   rx_full,
	output logic                  rx_push,
	output sd_pkg::rx_byte_t      rx_byte,

	output logic                  busy,

	// sd card pins
	output logic                  sdcs_n,
	output logic                  sdclk,
	output logic                  sddo,
	input  wire                   sddi
);

	localparam int div_w = (`SD_CLK_DIV > 1) ? $clog2(`SD_CLK_DIV) : 1;

	sd_pkg::spi_state_t state;
	logic [div_w-1:0]   div_cnt;
	logic [2:0]         bit_cnt;
	logic [7:0]         tx_sr;
	logic [7:0]         rx_sr;
	logic               half_end;
	logic               take;

	// a shift item waits while the reply would have nowhere to go
	assign take = (state == sd_pkg::SPI_IDLE) && !tx_empty &&
		(tx_head.kind == sd_pkg::TX_CS || !rx_full);

	assign tx_pop   = take;
	assign half_end = (div_cnt == div_w'(`SD_CLK_DIV - 1));
	assign busy     = (state != sd_pkg::SPI_IDLE);

	// last half period of the eighth bit
	assign rx_push = (state == sd_pkg::SPI_SHIFT) && half_end && sdclk && (bit_cnt == 3'd7);
	assign rx_byte = rx_sr;

	////////////////////
	// control
	////////////////////

	always_ff @(posedge fclk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= sd_pkg::SPI_IDLE;
			div_cnt <= '0;
			bit_cnt <= '0;
			sdcs_n  <= 1'b1;
			sdclk   <= 1'b0;
			sddo    <= 1'b1;
		end else begin
			case (state)
				sd_pkg::SPI_IDLE: begin
					if (take) begin
						div_cnt <= '0;
						bit_cnt <= '0;
						if (tx_head.kind == sd_pkg::TX_CS) begin
							state <= sd_pkg::SPI_CS;
						end else begin
							state <= sd_pkg::SPI_SHIFT;
							// msb ready before the first rise
							sddo  <= tx_head.data[7];
						end
					end
				end

				sd_pkg::SPI_CS: begin
					sdcs_n <= tx_sr[0];
					state  <= sd_pkg::SPI_IDLE;
				end

				sd_pkg::SPI_SHIFT: begin
					if (half_end) begin
						div_cnt <= '0;
						sdclk   <= !sdclk;
						// falling edge, next bit out
						if (sdclk) begin
							bit_cnt <= bit_cnt + 3'd1;
							if (bit_cnt == 3'd7) begin
								state <= sd_pkg::SPI_IDLE;
								sddo  <= 1'b1;
							end else begin
								sddo <= tx_sr[6];
							end
						end
					end else begin
						div_cnt <= div_cnt + div_w'(1);
					end
				end

				default: state <= sd_pkg::SPI_IDLE;
			endcase
		end
	end

	////////////////////
	// shift registers
	////////////////////

	always_ff @(posedge fclk) begin
		if (take)
			tx_sr <= tx_head.data;
		else if (state == sd_pkg::SPI_SHIFT && half_end && sdclk)
			tx_sr <= {tx_sr[6:0], 1'b0};

		// sddi taken as sdclk rises
		if (state == sd_pkg::SPI_SHIFT && half_end && !sdclk)
			rx_sr <= {rx_sr[6:0], sddi};
	end

endmodule

`default_nettype wire

/* hw/sync_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module sync_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  depth     = 8
) (
	input  wire           fclk,
	input  wire           rst_n,

	input  wire           push,
	input  wire payload_t wdata,
	input  wire           pop,

	output payload_t      rdata,
	output logic          full,
	output logic          empty
);

	localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
	localparam int cnt_w = $clog2(depth + 1);

	payload_t         mem [depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;

	function automatic logic [ptr_w-1:0] ptr_next(input logic [ptr_w-1:0] ptr);
		if (ptr == ptr_w'(depth - 1))
			return '0;
		return ptr + ptr_w'(1);
	endfunction

	////////////////////
	// storage
	////////////////////

	always_ff @(posedge fclk) begin
		if (push)
			mem[wr_ptr] <= wdata;
	end

	// head shown without a register stage
	assign rdata = mem[rd_ptr];

	////////////////////
	// pointers and fill level
	////////////////////

	always_ff @(posedge fclk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= ptr_next(wr_ptr);
			if (pop)
				rd_ptr <= ptr_next(rd_ptr);

			// push and pop together keep the level
			case ({push, pop})
				2'b10:   count <= count + cnt_w'(1);
				2'b01:   count <= count - cnt_w'(1);
				default: count <= count;
			endcase
		end
	end

	assign full  = (count == cnt_w'(depth));
	assign empty = (count == '0);

endmodule

`default_nettype wire

/* hw/zport_pkg.sv */
`default_nettype none

package zport_pkg;

	// one byte on the z80 data bus
	typedef logic [7:0] port_byte_t;

	// status byte seen at the control port
	typedef struct packed {
		logic [3:0] rsvd;
		logic       overrun;
		logic       busy;
		logic       rx_empty;
		logic       tx_full;
	} sd_status_t;

	// which sd port the low address selects
	typedef enum logic [1:0] {
		PORT_NONE,
		PORT_DATA,
		PORT_CTRL
	} port_sel_t;

endpackage

`default_nettype wire

/* hw/zsd_ports.sv */
`timescale 1ns/1ns
`default_nettype none

`include "sd_consts.svh"

module zsd_ports (
	input  wire                   fclk,
	input  wire                   rst_n,

	// z80 side, strobes already on fclk
	input  wire zport_pkg::port_byte_t a,
	input  wire zport_pkg::port_byte_t din,
	input  wire                   iowr,
	input  wire                   iord,
	output zport_pkg::port_byte_t dout,
	output logic                  dout_ena,

	// transmit queue
	input  wire                   tx_full,
	output logic                  tx_push,
	output sd_pkg::tx_item_t      tx_item,

	// receive queue
	input  wire                   rx_empty,
	input  wire sd_pkg::rx_byte_t rx_head,
	output logic                  rx_pop,

	// spi master
	input  wire                   busy
);

	zport_pkg::port_sel_t  sel;
	zport_pkg::sd_status_t status;
	logic                  hit;
	logic                  overrun;

	////////////////////
	// decode
	////////////////////

	always_comb begin
		if (a == `SD_DATA_PORT)
			sel = zport_pkg::PORT_DATA;
		else if (a == `SD_CTRL_PORT)
			sel = zport_pkg::PORT_CTRL;
		else
			sel = zport_pkg::PORT_NONE;
	end

	assign hit = (sel != zport_pkg::PORT_NONE);

	////////////////////
	// writes
	////////////////////

	// dropped when full, overrun flags it
	assign tx_push = iowr && hit && !tx_full;

	always_comb begin
		tx_item = '0;
		if (sel == zport_pkg::PORT_CTRL) begin
			tx_item.kind = sd_pkg::TX_CS;
			tx_item.data = {7'd0, din[0]};
		end else begin
			tx_item.kind = sd_pkg::TX_SHIFT;
			tx_item.data = din;
		end
	end

	// sticky until the status is read
	always_ff @(posedge fclk or negedge rst_n) begin
		if (!rst_n)
			overrun <= 1'b0;
		else if (iowr && hit && tx_full)
			overrun <= 1'b1;
		else if (iord && sel == zport_pkg::PORT_CTRL)
			overrun <= 1'b0;
	end

	////////////////////
	// reads
	////////////////////

	always_comb begin
		status          = '0;
		status.tx_full  = tx_full;
		status.rx_empty = rx_empty;
		status.busy     = busy;
		status.overrun  = overrun;
	end

	// head leaves the queue at the end of the read
	assign rx_pop = iord && sel == zport_pkg::PORT_DATA && !rx_empty;

	always_comb begin
		case (sel)
			zport_pkg::PORT_DATA: dout = rx_empty ? 8'hFF : rx_head;
			zport_pkg::PORT_CTRL: dout = zport_pkg::port_byte_t'(status);
			default:              dout = 8'hFF;
		endcase
	end

	assign dout_ena = iord && hit;

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build and run tb_sd_host with Verilator, pass only on the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_sd_host \
	-Mdir obj_dir -o sim_tb_sd_host || { echo "build failed"; exit 1; }

out=$(./obj_dir/sim_tb_sd_host)
echo "$out"
echo "$out" | grep -q "^Simulation completed successfully$" && exit 0 || exit 1

/* sim.f */
+incdir+hw
hw/zport_pkg.sv
hw/sd_pkg.sv
hw/zsd_ports.sv
hw/sync_fifo.sv
hw/sd_spi_master.sv
hw/sd_host.sv
testbench/sd_card_model.sv
testbench/tb_sd_host.sv

/* testbench/sd_card_model.sv */
`timescale 1ns/1ns
`default_nettype none

module sd_card_model (
	input  wire  sdcs_n,
	input  wire  sdclk,
	input  wire  sddo,
	output logic sddi
);

	// every byte clocked in while selected
	logic [7:0] log_mem [256];
	int         count = 0;

	int         bits = 0;
	int         since_fall = 0;
	int         edges_cs_high = 0;
	int         bytes_at_rise = 0;
	int         bits_at_rise = 0;
	logic [7:0] in_sr = 8'h00;
	logic [7:0] out_sr = 8'hff;
	logic [7:0] last = 8'h00;
	logic       reload = 1'b0;

	initial sddi = 1'b1;

	// new frame, first answer is ff
	always @(negedge sdcs_n) begin
		bits       = 0;
		since_fall = 0;
		reload     = 1'b0;
		out_sr     = 8'hff;
		sddi       = out_sr[7];
	end

	always @(posedge sdcs_n) begin
		bytes_at_rise = since_fall;
		bits_at_rise  = bits;
	end

	always @(posedge sdclk) begin
		if (sdcs_n) begin
			edges_cs_high++;
		end else begin
			in_sr = {in_sr[6:0], sddo};
			bits++;
			if (bits == 8) begin
				if (count < 256)
					log_mem[count] = in_sr;
				count++;
				since_fall++;
				bits   = 0;
				last   = in_sr;
				reload = 1'b1;
			end
		end
	end

	// next answer bit goes out while sdclk is low
	always @(negedge sdclk) begin
		if (!sdcs_n) begin
			if (reload) begin
				out_sr = ~last;
				reload = 1'b0;
			end else begin
				out_sr = {out_sr[6:0], 1'b1};
			end
			sddi = out_sr[7];
		end
	end

endmodule

`default_nettype wire

/* testbench/tb_sd_host.sv */
`timescale 1ns/1ns
`default_nettype none

`include "sd_consts.svh"

module tb_sd_host;

	localparam int shift_cycles = 16 * `SD_CLK_DIV + 1;
	// ten times the shift time of 60 bytes, polling included
	localparam int timeout_cycles = 60 * shift_cycles * 10;

	logic       fclk;
	logic       rst_n;
	logic [7:0] a;
	logic [7:0] din;
	logic       iowr;
	logic       iord;
	wire  [7:0] dout;
	wire        dout_ena;
	wire        sdcs_n;
	wire        sdclk;
	wire        sddo;
	wire        sddi;

	integer     seed = 32;
	int         cycles = 0;
	int         errors = 0;
	int         checks = 0;
	int         passed = 0;
	int         failed = 0;
	int         card_checked = 0;

	// model of the card bytes and of the replies
	logic [7:0] exp_card[$];
	logic [7:0] exp_reply[$];
	logic [7:0] last_sent = 8'h00;
	logic       frame_start = 1'b1;

	sd_host i_dut (
		.fclk     (fclk),
		.rst_n    (rst_n),
		.a        (a),
		.din      (din),
		.iowr     (iowr),
		.iord     (iord),
		.dout     (dout),
		.dout_ena (dout_ena),
		.sdcs_n   (sdcs_n),
		.sdclk    (sdclk),
		.sddo     (sddo),
		.sddi     (sddi)
	);

	sd_card_model u_card (
		.sdcs_n (sdcs_n),
		.sdclk  (sdclk),
		.sddo   (sddo),
		.sddi   (sddi)
	);

	initial begin
		fclk = 1'b0;
		forever #10 fclk = ~fclk;
	end

	always @(posedge fclk) begin
		cycles++;
		if (cycles > timeout_cycles) begin
			$display("timeout, run did not finish within %0d cycles", timeout_cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	////////////////////
	// checks
	////////////////////

	task automatic check_value(input string name, input logic [7:0] exp, input logic [7:0] got);
		checks++;
		assert (got === exp) else begin
			$display("[ERROR] %s expected %h got %h", name, exp, got);
			errors++;
		end
	endtask

	task automatic check_true(input bit cond, input string what);
		checks++;
		assert (cond) else begin
			$display("check failed: %s", what);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int start_errors);
		if (errors == start_errors) begin
			passed++;
			$display("test %s: pass", name);
		end else begin
			failed++;
			$display("test %s: fail with %0d errors", name, errors - start_errors);
		end
	endtask

	function automatic logic [7:0] status_byte(input logic tx_full, input logic rx_empty,
		input logic busy, input logic overrun);
		return {4'b0000, overrun, busy, rx_empty, tx_full};
	endfunction

	function automatic logic [7:0] rand_byte();
		return 8'($random(seed));
	endfunction

	////////////////////
	// z80 port access
	////////////////////

	// all bus tasks start and end 2 ns after a rising edge
	task automatic idle(input int n);
		repeat (n) @(posedge fclk);
		#2;
	endtask

	task automatic port_write(input logic [7:0] addr, input logic [7:0] data);
		a    = addr;
		din  = data;
		iowr = 1'b1;
		@(posedge fclk);
		#2;
		iowr = 1'b0;
	endtask

	task automatic port_read(input logic [7:0] addr, output logic [7:0] data, output logic ena);
		a    = addr;
		iord = 1'b1;
		@(negedge fclk);
		data = dout;
		ena  = dout_ena;
		@(posedge fclk);
		#2;
		iord = 1'b0;
	endtask

	task automatic read_status(output zport_pkg::sd_status_t st);
		logic [7:0] data;
		logic       ena;
		port_read(`SD_CTRL_PORT, data, ena);
		check_value("dout_ena", 8'h01, {7'd0, ena});
		st = zport_pkg::sd_status_t'(data);
	endtask

	task automatic read_reply();
		zport_pkg::sd_status_t st;
		logic [7:0]            data;
		logic                  ena;
		read_status(st);
		while (st.rx_empty)
			read_status(st);
		port_read(`SD_DATA_PORT, data, ena);
		check_value("dout_ena", 8'h01, {7'd0, ena});
		if (exp_reply.size() == 0)
			check_true(1'b0, "a reply came back for no byte sent");
		else
			check_value("dout", exp_reply.pop_front(), data);
	endtask

	task automatic drain_replies();
		while (exp_reply.size() > 0)
			read_reply();
	endtask

	// optionally reads replies while waiting
	task automatic wait_tx_space(input bit drain);
		zport_pkg::sd_status_t st;
		read_status(st);
		while (st.tx_full || (drain && !st.rx_empty)) begin
			if (drain && !st.rx_empty)
				read_reply();
			read_status(st);
		end
	endtask

	// two idle cycles in a row, nothing left to take
	task automatic wait_master_idle();
		zport_pkg::sd_status_t st;
		int                    quiet;
		quiet = 0;
		while (quiet < 2) begin
			read_status(st);
			quiet = st.busy ? 0 : quiet + 1;
		end
	endtask

	task automatic wait_cs_level(input logic level);
		while (sdcs_n !== level)
			@(negedge fclk);
		@(posedge fclk);
		#2;
	endtask

	////////////////////
	// reference model
	////////////////////

	task automatic send_byte(input logic [7:0] data);
		port_write(`SD_DATA_PORT, data);
		exp_card.push_back(data);
		exp_reply.push_back(frame_start ? 8'hff : ~last_sent);
		last_sent   = data;
		frame_start = 1'b0;
	endtask

	task automatic set_cs(input logic level);
		port_write(`SD_CTRL_PORT, {7'd0, level});
		if (!level)
			frame_start = 1'b1;
	endtask

	task automatic check_card();
		check_true(u_card.count == card_checked + exp_card.size(),
			"card received a different number of bytes than were sent");
		while (exp_card.size() > 0) begin
			if (card_checked < u_card.count)
				check_value("sddo", exp_card[0], u_card.log_mem[card_checked]);
			void'(exp_card.pop_front());
			card_checked++;
		end
		card_checked = u_card.count;
	endtask

	task automatic check_no_decode(input logic [7:0] addr);
		logic [7:0] data;
		logic       ena;
		port_read(addr, data, ena);
		check_value("dout_ena", 8'h00, {7'd0, ena});
	endtask

	////////////////////
	// tests
	////////////////////

	initial begin
		zport_pkg::sd_status_t st;
		logic [7:0]            data;
		logic [7:0]            addr;
		logic                  ena;
		int                    e0;
		int                    edges0;

		rst_n = 1'b0;
		a     = 8'h00;
		din   = 8'h00;
		iowr  = 1'b0;
		iord  = 1'b0;
		repeat (4) @(posedge fclk);
		#2;
		rst_n = 1'b1;
		idle(2);

		e0 = errors;
		check_value("sdcs_n", 8'h01, {7'd0, sdcs_n});
		check_value("sdclk", 8'h00, {7'd0, sdclk});
		read_status(st);
		check_value("status", status_byte(1'b0, 1'b1, 1'b0, 1'b0), st);
		port_read(`SD_DATA_PORT, data, ena);
		check_value("dout_ena", 8'h01, {7'd0, ena});
		check_value("dout", 8'hff, data);
		report_test("reset and idle status", e0);

		// cs items keep their place among the bytes
		e0     = errors;
		edges0 = u_card.edges_cs_high;
		set_cs(1'b0);
		repeat (3) send_byte(rand_byte());
		set_cs(1'b1);
		drain_replies();
		wait_cs_level(1'b1);
		check_true(u_card.edges_cs_high == edges0, "sdclk toggled while sdcs_n was high");
		check_true(u_card.bytes_at_rise == 3 && u_card.bits_at_rise == 0,
			"sdcs_n rose before the third byte was complete");
		check_card();
		report_test("ordered chip select", e0);

		e0 = errors;
		set_cs(1'b0);
		for (int i = 0; i < 20; i++) begin
			wait_tx_space(1'b1);
			send_byte(rand_byte());
		end
		drain_replies();
		set_cs(1'b1);
		wait_cs_level(1'b1);
		check_card();
		report_test("random stream and replies", e0);

		// fill the receive queue first so the master holds still
		e0 = errors;
		set_cs(1'b0);
		repeat (`SD_FIFO_DEPTH) send_byte(rand_byte());
		wait_master_idle();
		read_status(st);
		while (!st.tx_full) begin
			send_byte(rand_byte());
			read_status(st);
		end
		check_value("status", status_byte(1'b1, 1'b0, 1'b0, 1'b0), st);
		port_write(`SD_DATA_PORT, rand_byte());
		read_status(st);
		check_value("status", status_byte(1'b1, 1'b0, 1'b0, 1'b1), st);
		read_status(st);
		check_value("status", status_byte(1'b1, 1'b0, 1'b0, 1'b0), st);
		drain_replies();
		wait_tx_space(1'b0);
		set_cs(1'b1);
		wait_cs_level(1'b1);
		check_card();
		report_test("overrun", e0);

		e0 = errors;
		set_cs(1'b0);
		repeat (12) begin
			wait_tx_space(1'b0);
			send_byte(rand_byte());
		end
		wait_master_idle();
		idle(200);
		// stalled, receive queue full, rest still queued
		read_status(st);
		check_value("status", status_byte(1'b0, 1'b0, 1'b0, 1'b0), st);
		check_true(u_card.count - card_checked == `SD_FIFO_DEPTH,
			"master kept shifting with the receive queue full");
		drain_replies();
		read_status(st);
		check_value("status", status_byte(1'b0, 1'b1, 1'b0, 1'b0), st);
		set_cs(1'b1);
		wait_cs_level(1'b1);
		check_card();
		report_test("receive back-pressure", e0);

		e0 = errors;
		check_no_decode(8'h56);
		check_no_decode(8'h58);
		check_no_decode(8'h76);
		check_no_decode(8'h78);
		for (int i = 0; i < 16; i++) begin
			addr = rand_byte();
			if (addr != `SD_DATA_PORT && addr != `SD_CTRL_PORT)
				check_no_decode(addr);
		end
		report_test("decode", e0);

		$display("%0d tests passed, %0d failed, %0d checks, %0d errors",
			passed, failed, checks, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
